// File: build.f
design/io_pkg.sv
design/io_bus_if.sv
design/rr_arbiter.sv
design/io_arbiter.sv
design/io_decoder.sv
design/scratch_regs.sv
design/accum_regs.sv
design/io_subsystem.sv
sim/tb_clock_gen.sv
sim/io_subsystem_tb.sv

// File: design/accum_regs.sv
/*
 * Bank of accumulating registers, a store adds and a load
 * returns the running sum
 */
`timescale 1ns/1ns
`default_nettype none

module accum_regs
#(
	parameter int NUM_ACCUMS = 4
)
(
	input wire logic clk,
	input wire logic reset,
	io_bus_if.target bus
);

	localparam int IDX_W = NUM_ACCUMS > 1 ? $clog2(NUM_ACCUMS) : 1;

	logic [31:0] sums[NUM_ACCUMS];
	logic [31-io_pkg::REG_INDEX_LSB:0] word_addr;
	logic [IDX_W-1:0] acc_idx;
	logic [31:0] next_sum;

	// Word index, wrapped onto the number of accumulators
	assign word_addr = bus.address[31:io_pkg::REG_INDEX_LSB];
	assign acc_idx = IDX_W'(word_addr % NUM_ACCUMS);

	// The adder is 32 bits wide, so the sum wraps modulo 2^32
	assign next_sum = sums[acc_idx] + bus.write_data;

	// A load sees the sum before any store in the same cycle
	assign bus.read_data = bus.read_en ? sums[acc_idx] : 32'd0;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_ACCUMS; i++)
				sums[i] <= 32'd0;
		end
		else if (bus.write_en)
		begin
			sums[acc_idx] <= next_sum;
		end
	end

endmodule

`default_nettype wire

// File: design/io_arbiter.sv
/*
 * Core request arbitration, issue on the I/O bus and
 * return of the response packet one cycle after the bus access
 */
`timescale 1ns/1ns
`default_nettype none

module io_arbiter
#(
	parameter int NUM_CORES = 4
)
(
	input wire logic clk,
	input wire logic reset,
	input io_pkg::ioreq_packet_t io_request[NUM_CORES],
	output logic ready[NUM_CORES],
	output io_pkg::iorsp_packet_t response,
	io_bus_if.initiator bus
);

	logic [NUM_CORES-1:0] arb_request;
	logic [NUM_CORES-1:0] grant_oh;
	io_pkg::core_id_t grant_idx;
	logic grant_valid;
	io_pkg::ioreq_packet_t granted_req;

	// A bus access is in progress in this cycle
	logic request_sent;
	io_pkg::core_id_t request_core;
	io_pkg::thread_idx_t request_thread;

	// Response register contents
	logic rsp_valid;
	io_pkg::core_id_t rsp_core;
	io_pkg::thread_idx_t rsp_thread;
	logic [31:0] rsp_read_value;

	// The grant doubles as the ready strobe, so a granted request is accepted at the next edge
	genvar core;
	generate
		for (core = 0; core < NUM_CORES; core++)
		begin : handshake_gen
			assign arb_request[core] = io_request[core].valid;
			assign ready[core] = grant_oh[core];
		end
	endgenerate

	generate
		if (NUM_CORES > 1)
		begin : arb_gen
			rr_arbiter #(.NUM_CORES(NUM_CORES)) i_rr_arbiter
			(
				.clk(clk),
				.reset(reset),
				.request(arb_request),
				.grant_oh(grant_oh),
				.grant_idx(grant_idx)
			);
		end
		else
		begin : single_gen
			// A lone core wins whenever it asks
			assign grant_oh = arb_request;
			assign grant_idx = '0;
		end
	endgenerate

	assign grant_valid = |grant_oh;

	// AND-OR select of the winning request
	always_comb
	begin
		granted_req = '0;
		for (int i = 0; i < NUM_CORES; i++)
		begin
			if (grant_oh[i])
				granted_req = granted_req | io_request[i];
		end
	end

	// Enables last exactly one cycle, and the response follows one cycle later
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			bus.write_en <= 1'b0;
			bus.read_en <= 1'b0;
			request_sent <= 1'b0;
			rsp_valid <= 1'b0;
		end
		else
		begin
			bus.write_en <= grant_valid && granted_req.is_store;
			bus.read_en <= grant_valid && !granted_req.is_store;
			request_sent <= grant_valid;
			rsp_valid <= request_sent;
		end
	end

	always_ff @(posedge clk)
	begin
		if (grant_valid)
		begin
			bus.address <= granted_req.address;
			bus.write_data <= granted_req.value;
			request_core <= grant_idx;
			request_thread <= granted_req.thread_idx;
		end

		// Read data is sampled at the edge that ends the bus cycle
		if (request_sent)
		begin
			rsp_core <= request_core;
			rsp_thread <= request_thread;
			rsp_read_value <= bus.read_data;
		end
	end

	assign response.valid = rsp_valid;
	assign response.core = rsp_core;
	assign response.thread_idx = rsp_thread;
	assign response.read_value = rsp_read_value;

endmodule

`default_nettype wire

// File: design/io_bus_if.sv
/*
 * Single-cycle I/O bus with initiator and target modports
 */
`timescale 1ns/1ns
`default_nettype none

interface io_bus_if;

	// At most one of the two enables is high in any cycle
	logic write_en;
	logic read_en;
	logic [31:0] address;
	logic [31:0] write_data;

	// Valid in the same cycle as read_en, with no extra latency
	logic [31:0] read_data;

	// The side that issues accesses
	modport initiator
	(
		output write_en,
		output read_en,
		output address,
		output write_data,
		input read_data
	);

	// The side that completes accesses
	modport target
	(
		input write_en,
		input read_en,
		input address,
		input write_data,
		output read_data
	);

endinterface

`default_nettype wire

// File: design/io_decoder.sv
/*
 * Address decoder that routes bus enables to the scratch or
 * accumulator bank and selects the returned read data
 */
`timescale 1ns/1ns
`default_nettype none

module io_decoder
(
	io_bus_if.target main,
	io_bus_if.initiator scratch,
	io_bus_if.initiator accum
);

	// High when the access targets the accumulator bank
	logic sel_accum;

	// This is the only place that knows the address map
	assign sel_accum = main.address[io_pkg::DEVICE_SEL_BIT];

	// Both banks see the address and data, only the chosen one sees an enable
	assign scratch.address = main.address;
	assign scratch.write_data = main.write_data;
	assign scratch.write_en = main.write_en && !sel_accum;
	assign scratch.read_en = main.read_en && !sel_accum;

	assign accum.address = main.address;
	assign accum.write_data = main.write_data;
	assign accum.write_en = main.write_en && sel_accum;
	assign accum.read_en = main.read_en && sel_accum;

	// Read data comes back in the same cycle
	assign main.read_data = sel_accum ? accum.read_data : scratch.read_data;

endmodule

`default_nettype wire

// File: design/io_pkg.sv
/*
 * Shared types of the uncached I/O path: core and thread identifiers,
 * request and response packets, and the address map constants.
 */
`default_nettype none

package io_pkg;

	// Index of a requesting core, wide enough for up to 16 cores
	typedef logic [3:0] core_id_t;

	// Hardware thread within one core
	typedef logic [1:0] thread_idx_t;

	// One core's uncached load or store request (68 bits)
	typedef struct packed
	{
		logic valid;
		logic is_store;
		thread_idx_t thread_idx;
		logic [31:0] address;
		logic [31:0] value;
	} ioreq_packet_t;

	// Response returned to the core and thread that issued the request (39 bits)
	// For a store the read value carries no meaning
	typedef struct packed
	{
		logic valid;
		core_id_t core;
		thread_idx_t thread_idx;
		logic [31:0] read_value;
	} iorsp_packet_t;

	// Address bit that picks the peripheral
	// Clear selects the scratch registers, set selects the accumulators
	localparam int DEVICE_SEL_BIT = 8;

	// Registers are word addressed, so the register index starts above the byte offset
	localparam int REG_INDEX_LSB = 2;

endpackage

`default_nettype wire

// File: design/io_subsystem.sv
/*
 * Top level of the uncached I/O path: request packing, arbiter,
 * address decoder and the two register banks
 */
`timescale 1ns/1ns
`default_nettype none

module io_subsystem
#(
	parameter int NUM_CORES = 4,
	parameter int NUM_SCRATCH_REGS = 8,
	parameter int NUM_ACCUMS = 4
)
(
	input wire logic clk,
	input wire logic reset,

	// One request per core, held until req_ready is seen at an edge
	input wire logic [NUM_CORES-1:0] req_valid,
	input wire logic [NUM_CORES-1:0] req_is_store,
	input io_pkg::thread_idx_t req_thread[NUM_CORES],
	input wire logic [31:0] req_address[NUM_CORES],
	input wire logic [31:0] req_value[NUM_CORES],
	output logic [NUM_CORES-1:0] req_ready,

	// Response, valid for one cycle with no back-pressure
	output logic rsp_valid,
	output io_pkg::core_id_t rsp_core,
	output io_pkg::thread_idx_t rsp_thread,
	output logic [31:0] rsp_read_value
);

	io_pkg::ioreq_packet_t io_request[NUM_CORES];
	logic ready[NUM_CORES];
	io_pkg::iorsp_packet_t response;

	io_bus_if bus_main();
	io_bus_if bus_scratch();
	io_bus_if bus_accum();

	// Pack each core's plain ports into a request packet
	genvar core;
	generate
		for (core = 0; core < NUM_CORES; core++)
		begin : pack_gen
			assign io_request[core].valid = req_valid[core];
			assign io_request[core].is_store = req_is_store[core];
			assign io_request[core].thread_idx = req_thread[core];
			assign io_request[core].address = req_address[core];
			assign io_request[core].value = req_value[core];
			assign req_ready[core] = ready[core];
		end
	endgenerate

	assign rsp_valid = response.valid;
	assign rsp_core = response.core;
	assign rsp_thread = response.thread_idx;
	assign rsp_read_value = response.read_value;

	io_arbiter #(.NUM_CORES(NUM_CORES)) i_io_arbiter
	(
		.clk(clk),
		.reset(reset),
		.io_request(io_request),
		.ready(ready),
		.response(response),
		.bus(bus_main.initiator)
	);

	io_decoder i_io_decoder
	(
		.main(bus_main.target),
		.scratch(bus_scratch.initiator),
		.accum(bus_accum.initiator)
	);

	scratch_regs #(.NUM_SCRATCH_REGS(NUM_SCRATCH_REGS)) i_scratch_regs
	(
		.clk(clk),
		.reset(reset),
		.bus(bus_scratch.target)
	);

	accum_regs #(.NUM_ACCUMS(NUM_ACCUMS)) i_accum_regs
	(
		.clk(clk),
		.reset(reset),
		.bus(bus_accum.target)
	);

endmodule

`default_nettype wire

// File: design/rr_arbiter.sv
/*
 * Round-robin arbiter with a rotating priority pointer,
 * one-hot grant and binary grant index
 */
`timescale 1ns/1ns
`default_nettype none

module rr_arbiter
#(
	parameter int NUM_CORES = 4
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic [NUM_CORES-1:0] request,
	output logic [NUM_CORES-1:0] grant_oh,
	output io_pkg::core_id_t grant_idx
);

	// The core that has the highest priority in this cycle
	io_pkg::core_id_t priority_ptr;

	// Scan from the pointer and take the first requester found
	always_comb
	begin
		int cand;
		logic found;

		grant_oh = '0;
		found = 1'b0;
		for (int i = 0; i < NUM_CORES; i++)
		begin
			cand = int'(priority_ptr) + i;
			if (cand >= NUM_CORES)
				cand = cand - NUM_CORES;

			if (!found && request[cand])
			begin
				grant_oh[cand] = 1'b1;
				found = 1'b1;
			end
		end
	end

	// Encode the one-hot grant, at most one bit is ever set
	always_comb
	begin
		grant_idx = '0;
		for (int i = 0; i < NUM_CORES; i++)
		begin
			if (grant_oh[i])
				grant_idx = grant_idx | io_pkg::core_id_t'(i);
		end
	end

	// After a grant the core just past the winner gets first pick
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			priority_ptr <= '0;
		else if (|grant_oh)
		begin
			if (grant_idx == io_pkg::core_id_t'(NUM_CORES - 1))
				priority_ptr <= '0;
			else
				priority_ptr <= grant_idx + 4'd1;
		end
	end

endmodule

`default_nettype wire

// File: design/scratch_regs.sv
/*
 * Bank of plain read/write scratch registers
 */
`timescale 1ns/1ns
`default_nettype none

module scratch_regs
#(
	parameter int NUM_SCRATCH_REGS = 8
)
(
	input wire logic clk,
	input wire logic reset,
	io_bus_if.target bus
);

	localparam int IDX_W = NUM_SCRATCH_REGS > 1 ? $clog2(NUM_SCRATCH_REGS) : 1;

	logic [31:0] regs[NUM_SCRATCH_REGS];
	logic [31-io_pkg::REG_INDEX_LSB:0] word_addr;
	logic [IDX_W-1:0] reg_idx;

	// Word index, wrapped onto the bank size
	assign word_addr = bus.address[31:io_pkg::REG_INDEX_LSB];
	assign reg_idx = IDX_W'(word_addr % NUM_SCRATCH_REGS);

	// Reads are combinational and return zero when not enabled
	assign bus.read_data = bus.read_en ? regs[reg_idx] : 32'd0;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_SCRATCH_REGS; i++)
				regs[i] <= 32'd0;
		end
		else if (bus.write_en)
		begin
			regs[reg_idx] <= bus.write_data;
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the I/O subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module io_subsystem_tb -f build.f -o io_subsystem_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/io_subsystem_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
fi
exit $status

// File: sim/io_subsystem_tb.sv
/*
 * Random-stimulus testbench for the uncached I/O path, with a model of
 * both register banks, the round-robin rule and the response timing
 */
`timescale 1ns/1ns
`default_nettype none

module io_subsystem_tb;

	localparam int NUM_CORES = 4;
	localparam int NUM_SCRATCH_REGS = 8;
	localparam int NUM_ACCUMS = 4;

	// One response the model expects, with the edge count at which it must show up
	typedef struct packed
	{
		logic [31:0] due;
		logic [3:0] core;
		logic [1:0] thread;
		logic is_store;
		logic [31:0] value;
	} expect_t;

	// A directed access that core 0 always issues
	typedef struct packed
	{
		logic is_store;
		logic [1:0] thread;
		logic [31:0] addr;
		logic [31:0] value;
	} dir_req_t;

	logic clk;
	logic reset;
	logic [NUM_CORES-1:0] req_valid;
	logic [NUM_CORES-1:0] req_is_store;
	io_pkg::thread_idx_t req_thread[NUM_CORES];
	logic [31:0] req_address[NUM_CORES];
	logic [31:0] req_value[NUM_CORES];
	logic [NUM_CORES-1:0] req_ready;
	logic rsp_valid;
	io_pkg::core_id_t rsp_core;
	io_pkg::thread_idx_t rsp_thread;
	logic [31:0] rsp_read_value;

	// Model state
	logic [31:0] scratch_model[NUM_SCRATCH_REGS];
	logic [31:0] accum_model[NUM_ACCUMS];
	int model_ptr;
	int wait_cnt[NUM_CORES];
	logic [NUM_CORES-1:0] accepted;
	expect_t exp_q[$];
	dir_req_t dir_q[$];

	// Stimulus knobs. Region 0 is scratch, 1 is the accumulators and 2 is either
	int seed;
	int edge_cnt;
	int region;
	int req_rate;
	logic [NUM_CORES-1:0] active_mask;

	tb_clock_gen #(.PERIOD_NS(100)) i_clock_gen
	(
		.clk(clk)
	);

	io_subsystem
	#(
		.NUM_CORES(NUM_CORES),
		.NUM_SCRATCH_REGS(NUM_SCRATCH_REGS),
		.NUM_ACCUMS(NUM_ACCUMS)
	)
	i_dut
	(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req_is_store(req_is_store),
		.req_thread(req_thread),
		.req_address(req_address),
		.req_value(req_value),
		.req_ready(req_ready),
		.rsp_valid(rsp_valid),
		.rsp_core(rsp_core),
		.rsp_thread(rsp_thread),
		.rsp_read_value(rsp_read_value)
	);

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
			report_failure($sformatf("Mismatch at %0t ns: %s, got %h, expected %h",
				$time, what, actual, expected));
	endtask

	task automatic queue_access(input logic is_store, input logic [31:0] addr,
		input logic [31:0] value);
		dir_req_t d;

		d.is_store = is_store;
		d.thread = 2'(dir_q.size());
		d.addr = addr;
		d.value = value;
		dir_q.push_back(d);
	endtask

	// Work still in flight anywhere between the driver and the response register
	function automatic logic requests_pending();
		return dir_q.size() > 0 || req_valid != '0 || exp_q.size() > 0;
	endfunction

	// Sample at the falling edge, where every output has settled
	task automatic check_cycle();
		expect_t due_rsp;
		int win;
		int c;
		int idx;
		int unsigned word;
		logic [NUM_CORES-1:0] exp_grant;

		@(negedge clk);

		// The response register loads on the edge right after the bus cycle
		if (exp_q.size() > 0 && exp_q[0].due == 32'(edge_cnt))
		begin
			due_rsp = exp_q.pop_front();
			check_equal(32'(rsp_valid), 32'd1, "response valid");
			check_equal(32'(rsp_core), 32'(due_rsp.core), "response core");
			check_equal(32'(rsp_thread), 32'(due_rsp.thread), "response thread");
			if (!due_rsp.is_store)
				check_equal(rsp_read_value, due_rsp.value, "load data");
		end
		else
			check_equal(32'(rsp_valid), 32'd0, "response valid with nothing due");

		// A core that keeps losing at the DUT must still be served within one full round
		if (req_ready != '0)
		begin
			for (int i = 0; i < NUM_CORES; i++)
			begin
				if (req_ready[i])
					wait_cnt[i] = 0;
				else if (req_valid[i])
				begin
					wait_cnt[i]++;
					if (wait_cnt[i] > NUM_CORES)
						report_failure($sformatf("Core %0d waited more than %0d grants",
							i, NUM_CORES));
				end
			end
		end

		// The first valid core at or after the pointer wins
		win = -1;
		for (int i = 0; i < NUM_CORES; i++)
		begin
			c = (model_ptr + i) % NUM_CORES;
			if (win < 0 && req_valid[c])
				win = c;
		end
		exp_grant = '0;
		if (win >= 0)
			exp_grant[win] = 1'b1;
		check_equal(32'(req_ready), 32'(exp_grant), "req_ready grant");

		if (win >= 0)
		begin
			accepted[win] = 1'b1;
			model_ptr = (win + 1) % NUM_CORES;

			// Loads see every store issued before them, so the model updates in issue order
			due_rsp.due = 32'(edge_cnt + 2);
			due_rsp.core = 4'(win);
			due_rsp.thread = req_thread[win];
			due_rsp.is_store = req_is_store[win];
			word = req_address[win] >> 2;
			if (req_address[win][io_pkg::DEVICE_SEL_BIT])
			begin
				idx = int'(word % NUM_ACCUMS);
				due_rsp.value = accum_model[idx];
				if (req_is_store[win])
					accum_model[idx] = accum_model[idx] + req_value[win];
			end
			else
			begin
				idx = int'(word % NUM_SCRATCH_REGS);
				due_rsp.value = scratch_model[idx];
				if (req_is_store[win])
					scratch_model[idx] = req_value[win];
			end
			exp_q.push_back(due_rsp);
		end
	endtask

	// A core holds its request until accepted, then picks a new one or goes idle
	task automatic drive_requests();
		dir_req_t d;
		logic [31:0] rnd;
		logic [31:0] addr;

		for (int c = 0; c < NUM_CORES; c++)
		begin
			if (!req_valid[c] || accepted[c])
			begin
				rnd = $random(seed);
				if (c == 0 && dir_q.size() > 0)
				begin
					d = dir_q.pop_front();
					req_valid[c] <= 1'b1;
					req_is_store[c] <= d.is_store;
					req_thread[c] <= d.thread;
					req_address[c] <= d.addr;
					req_value[c] <= d.value;
				end
				else if (active_mask[c] && int'(rnd[1:0]) < req_rate)
				begin
					addr = $random(seed);
					addr[1:0] = 2'b00;
					if (region == 0)
						addr[io_pkg::DEVICE_SEL_BIT] = 1'b0;
					else if (region == 1)
						addr[io_pkg::DEVICE_SEL_BIT] = 1'b1;
					req_valid[c] <= 1'b1;
					req_is_store[c] <= rnd[2];
					req_thread[c] <= rnd[4:3];
					req_address[c] <= addr;
					req_value[c] <= $random(seed);
				end
				else
					req_valid[c] <= 1'b0;
			end
		end
		accepted = '0;
	endtask

	task automatic step_cycle();
		check_cycle();
		@(posedge clk);
		edge_cnt++;
		drive_requests();
	endtask

	task automatic run_cycles(input int n);
		for (int i = 0; i < n; i++)
			step_cycle();
	endtask

	task automatic drain_requests(input string phase);
		int n;

		n = 0;
		active_mask = '0;
		while (requests_pending() && n < 200)
		begin
			step_cycle();
			n++;
		end
		if (requests_pending())
			report_failure($sformatf("Timeout: requests still pending after %s", phase));
	endtask

	initial
	begin
		seed = 32'h6e19_fe19;
		reset = 1'b1;
		req_valid = '0;
		req_is_store = '0;
		for (int i = 0; i < NUM_CORES; i++)
		begin
			req_thread[i] = '0;
			req_address[i] = '0;
			req_value[i] = '0;
			wait_cnt[i] = 0;
		end
		for (int i = 0; i < NUM_SCRATCH_REGS; i++)
			scratch_model[i] = '0;
		for (int i = 0; i < NUM_ACCUMS; i++)
			accum_model[i] = '0;
		model_ptr = 0;
		accepted = '0;
		active_mask = '0;
		region = 0;
		req_rate = 0;
		edge_cnt = 0;

		// Nothing may be granted or returned while reset is held
		for (int i = 0; i < 16; i++)
		begin
			@(negedge clk);
			check_equal(32'(req_ready), 32'd0, "req_ready during reset");
			check_equal(32'(rsp_valid), 32'd0, "rsp_valid during reset");
		end
		@(posedge clk);
		reset <= 1'b0;

		// Every register of both banks reads back as zero
		for (int i = 0; i < NUM_SCRATCH_REGS; i++)
			queue_access(1'b0, 32'(i * 4), 32'd0);
		for (int i = 0; i < NUM_ACCUMS; i++)
			queue_access(1'b0, 32'h100 | 32'(i * 4), 32'd0);
		drain_requests("reset readback");

		// A single core works on the scratch bank while the upper address bits exercise the wrap
		region = 0;
		req_rate = 3;
		active_mask = 4'b0001;
		run_cycles(300);
		drain_requests("scratch phase");

		// Accumulator sums that are forced past 2^32
		queue_access(1'b1, 32'h100, 32'hffff_fff0);
		queue_access(1'b1, 32'h100, 32'h0000_0025);
		queue_access(1'b0, 32'h100, 32'd0);
		queue_access(1'b1, 32'h10c, 32'h8000_0001);
		queue_access(1'b1, 32'h10c, 32'h8000_0001);
		queue_access(1'b0, 32'h10c, 32'd0);
		queue_access(1'b0, 32'h11c, 32'd0);
		region = 1;
		active_mask = 4'b0001;
		run_cycles(200);
		drain_requests("accumulator phase");

		// All cores with random threads and addresses in both banks
		region = 2;
		req_rate = 3;
		active_mask = 4'b1111;
		run_cycles(400);
		drain_requests("mixed phase");

		// Every core requests on every cycle, so the grant must rotate
		req_rate = 4;
		active_mask = 4'b1111;
		run_cycles(200);
		drain_requests("saturated phase");

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
/*
 * Free-running testbench clock
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
#(
	parameter int PERIOD_NS = 100
)
(
	output logic clk
);

	// Start low so the first rising edge comes half a period in
	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

`default_nettype wire
